// File: icache_sys.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_tag_ram.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
verif/tb_icache_mem.sv
verif/tb_icache.sv

// File: rtl/icache_consts.svh
/* Geometry constants for the two-way instruction cache.
   Included by the package and by every RTL module that sizes arrays or ports. */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// ------------------------------
// Array geometry
// ------------------------------

// Sets per way. Must be a power of two.
`define ICACHE_SETS 64

// Fixed at two, one hit-way bit and one LRU bit per set.
`define ICACHE_WAYS 2

// ------------------------------
// Word and address layout
// ------------------------------

// Instruction word and address width.
`define ICACHE_WORD_W 32
// Byte offset below the set index.
`define ICACHE_OFFSET_W 2

`endif

// File: rtl/icache_ctrl.sv
/* Cache controller: lookup/fill FSM, per-set LRU bits, way selection and output mux.
   Sits between the CPU fetch port, the two way stores and the memory request port. */
`timescale 1ns/100ps
`default_nettype none

`include "icache_consts.svh"

module icache_ctrl (
  input  logic                                         clk,
  input  logic                                         resetn,
  // CPU fetch side.
  input  logic [`ICACHE_WORD_W-1:0]                    cpu_addr_i,
  input  logic                                         cpu_valid_i,
  output logic [`ICACHE_WORD_W-1:0]                    cpu_dout_o,
  output logic                                         cpu_ready_o,
  // Memory side.
  output icache_pkg::mem_req_t                         mem_req_o,
  input  logic [`ICACHE_WORD_W-1:0]                    ram_rdata_i,
  input  logic                                         ram_ready_i,
  // Way stores.
  output icache_pkg::addr_split_t                      way_addr_o,
  output logic                                         way_we_o,
  output logic [`ICACHE_WAYS-1:0]                      way_en_o,
  output logic [`ICACHE_WORD_W-1:0]                    way_payload_o,
  input  logic [`ICACHE_WAYS-1:0]                      way_hit_i,
  input  logic [`ICACHE_WAYS-1:0][`ICACHE_WORD_W-1:0]  way_payload_i
);
  import icache_pkg::*;

  ctrl_state_t               state_q;
  ctrl_state_t               state_d;
  logic                      hit_way_q;
  logic                      hit_way_d;
  logic [`ICACHE_SETS-1:0]   lru_q;
  logic [`ICACHE_SETS-1:0]   lru_d;
  logic [`ICACHE_WORD_W-1:0] req_addr_q;

  addr_split_t               req_split;
  logic                      any_hit;
  logic                      fill_way;
  logic                      mem_valid;

  // ------------------------------
  // Request and address split
  // ------------------------------

  // Live address during lookup and the captured copy afterwards.
  assign req_split = (state_q == IDLE_LOOKUP) ? cpu_addr_i : req_addr_q;

  assign any_hit  = |way_hit_i;
  // LRU bit names the way to replace.
  assign fill_way = lru_q[req_split.index];

  assign way_addr_o    = req_split;
  assign way_payload_o = ram_rdata_i;

  assign mem_req_o = '{valid: mem_valid, addr: req_addr_q};

  // ------------------------------
  // Next state and outputs
  // ------------------------------

  always_comb begin
    state_d     = state_q;
    hit_way_d   = hit_way_q;
    lru_d       = lru_q;
    way_en_o    = '0;
    way_we_o    = 1'b0;
    mem_valid   = 1'b0;
    cpu_ready_o = 1'b0;
    cpu_dout_o  = ram_rdata_i;

    case (state_q)
      IDLE_LOOKUP: begin
        // Requests are accepted only here, where cpu_ready_o is low.
        // Both ways compare tags in the acceptance cycle.
        way_en_o = {`ICACHE_WAYS{cpu_valid_i}};
        if (cpu_valid_i) begin
          hit_way_d = way_hit_i[1];
          state_d   = any_hit ? HIT_RESP : FILL_WAIT;
        end
      end

      FILL_WAIT: begin
        // Request held until the memory answers.
        mem_valid = 1'b1;
        if (ram_ready_i) begin
          way_we_o               = 1'b1;
          way_en_o[fill_way]     = 1'b1;
          lru_d[req_split.index] = ~fill_way;
          cpu_ready_o            = 1'b1;
          state_d                = IDLE_LOOKUP;
        end
      end

      HIT_RESP: begin
        way_en_o[hit_way_q]    = 1'b1;
        // The other way becomes the next victim.
        lru_d[req_split.index] = ~hit_way_q;
        cpu_ready_o            = 1'b1;
        cpu_dout_o             = way_payload_i[hit_way_q];
        state_d                = IDLE_LOOKUP;
      end

      default: begin
        state_d = IDLE_LOOKUP;
      end
    endcase
  end

  // ------------------------------
  // Registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q   <= IDLE_LOOKUP;
      hit_way_q <= 1'b0;
      lru_q     <= '0;
    end else begin
      state_q   <= state_d;
      hit_way_q <= hit_way_d;
      lru_q     <= lru_d;
    end
  end

  // Request address kept for the fill and the memory port.
  always_ff @(posedge clk) begin
    if ((state_q == IDLE_LOOKUP) && cpu_valid_i) begin
      req_addr_q <= cpu_addr_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/icache_pkg.sv
/* Shared types for the instruction cache: address split, memory request, FSM states.
   Imported by the controller and the top level, and used by the tag RAM ports. */
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

  // Derived field widths.
  localparam int IDX_W = $clog2(`ICACHE_SETS);
  localparam int TAG_W = `ICACHE_WORD_W - IDX_W - `ICACHE_OFFSET_W;

  // ------------------------------
  // Address split, tag on top.
  // ------------------------------
  typedef struct packed {
    logic [TAG_W-1:0]            tag;
    logic [IDX_W-1:0]            index;
    logic [`ICACHE_OFFSET_W-1:0] offset;
  } addr_split_t;

  // Request toward the backing memory.
  typedef struct packed {
    logic                      valid;
    logic [`ICACHE_WORD_W-1:0] addr;
  } mem_req_t;

  // Controller states.
  typedef enum logic [1:0] {
    IDLE_LOOKUP = 2'd0,
    FILL_WAIT   = 2'd1,
    HIT_RESP    = 2'd2
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: rtl/icache_tag_ram.sv
/* One cache way: per-set tag, valid and word arrays.
   Lookup is combinational on the set index, fills are written on the clock edge. */
`timescale 1ns/100ps
`default_nettype none

`include "icache_consts.svh"

module icache_tag_ram (
  input  logic                      clk,
  input  logic                      resetn,
  input  icache_pkg::addr_split_t   addr_i,
  input  logic                      we_i,
  input  logic                      en_i,
  input  logic [`ICACHE_WORD_W-1:0] payload_i,
  output logic                      hit_o,
  output logic [`ICACHE_WORD_W-1:0] payload_o
);
  import icache_pkg::*;

  // ------------------------------
  // Storage
  // ------------------------------

  logic [TAG_W-1:0]          tag_mem  [`ICACHE_SETS];
  logic [`ICACHE_WORD_W-1:0] data_mem [`ICACHE_SETS];
  logic [`ICACHE_SETS-1:0]   valid_q;

  logic                      write_set;
  logic [TAG_W-1:0]          stored_tag;
  logic                      tag_match;

  assign write_set = we_i && en_i;

  // Valid bits are the only state cleared in reset.
  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q <= '0;
    end else if (write_set) begin
      valid_q[addr_i.index] <= 1'b1;
    end
  end

  // Tag and word are written together on a fill.
  always_ff @(posedge clk) begin
    if (write_set) begin
      tag_mem[addr_i.index]  <= addr_i.tag;
      data_mem[addr_i.index] <= payload_i;
    end
  end

  // ------------------------------
  // Lookup
  // ------------------------------

  assign stored_tag = tag_mem[addr_i.index];
  assign tag_match  = (stored_tag == addr_i.tag);

  // Hit only when this way is enabled for the access.
  assign hit_o = en_i && valid_q[addr_i.index] && tag_match;

  // Word is presented regardless of hit, the controller picks the way.
  assign payload_o = data_mem[addr_i.index];

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
/* Instruction cache top level with CPU fetch and memory ports.
   Joins the controller to the two way stores and unpacks the memory request. */
`timescale 1ns/100ps
`default_nettype none

`include "icache_consts.svh"

module icache_top (
  input  logic                      clk,
  input  logic                      resetn,
  // CPU fetch port.
  input  logic [`ICACHE_WORD_W-1:0] cpu_addr_i,
  input  logic                      cpu_valid_i,
  output logic [`ICACHE_WORD_W-1:0] cpu_dout_o,
  output logic                      cpu_ready_o,
  // Memory port.
  output logic [`ICACHE_WORD_W-1:0] ram_addr_o,
  output logic                      ram_valid_o,
  input  logic [`ICACHE_WORD_W-1:0] ram_rdata_i,
  input  logic                      ram_ready_i
);
  import icache_pkg::*;

  mem_req_t                                     mem_req;
  addr_split_t                                  way_addr;
  logic                                         way_we;
  logic [`ICACHE_WAYS-1:0]                      way_en;
  logic [`ICACHE_WORD_W-1:0]                    way_wdata;
  logic [`ICACHE_WAYS-1:0]                      way_hit;
  logic [`ICACHE_WAYS-1:0][`ICACHE_WORD_W-1:0]  way_rdata;

  // ------------------------------
  // Controller
  // ------------------------------

  icache_ctrl u_ctrl (
    .clk           (clk),
    .resetn        (resetn),
    .cpu_addr_i    (cpu_addr_i),
    .cpu_valid_i   (cpu_valid_i),
    .cpu_dout_o    (cpu_dout_o),
    .cpu_ready_o   (cpu_ready_o),
    .mem_req_o     (mem_req),
    .ram_rdata_i   (ram_rdata_i),
    .ram_ready_i   (ram_ready_i),
    .way_addr_o    (way_addr),
    .way_we_o      (way_we),
    .way_en_o      (way_en),
    .way_payload_o (way_wdata),
    .way_hit_i     (way_hit),
    .way_payload_i (way_rdata)
  );

  // Memory request onto the external port.
  assign ram_valid_o = mem_req.valid;
  assign ram_addr_o  = mem_req.addr;

  // ------------------------------
  // Way stores
  // ------------------------------

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    icache_tag_ram u_tag_ram (
      .clk       (clk),
      .resetn    (resetn),
      .addr_i    (way_addr),
      .we_i      (way_we),
      .en_i      (way_en[w]),
      .payload_i (way_wdata),
      .hit_o     (way_hit[w]),
      .payload_o (way_rdata[w])
    );
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the cache and its testbench with Verilator, run it, then judge the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing -f icache_sys.f --top-module tb_icache -o tb_icache_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_icache_sim > "$LOG" 2>&1
cat "$LOG"
grep -q "TEST FAILED" "$LOG" && { echo "Simulation reported a failure"; exit 1; }
grep -q "TEST OK" "$LOG" || { echo "Simulation ended without a pass message"; exit 1; }
echo "Simulation passed"
exit 0

// File: verif/tb_icache.sv
/* Testbench for the two-way instruction cache with random fetches from a small address pool.
   Each fetch is checked cycle by cycle against a reference model of tags, valids and LRU. */
`timescale 1ns/100ps
`default_nettype none

`include "icache_consts.svh"

module tb_icache;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_REQ    = 400;
  localparam int NUM_SETS   = 12;
  localparam int NUM_TAGS   = 3;
  localparam int IDX_W      = $clog2(`ICACHE_SETS);
  localparam int TAG_W      = `ICACHE_WORD_W - IDX_W - `ICACHE_OFFSET_W;

  logic                      clk;
  logic                      resetn;
  logic [`ICACHE_WORD_W-1:0] cpu_addr;
  logic                      cpu_valid;
  logic [`ICACHE_WORD_W-1:0] cpu_dout;
  logic                      cpu_ready;
  logic [`ICACHE_WORD_W-1:0] ram_addr;
  logic                      ram_valid;
  logic [`ICACHE_WORD_W-1:0] ram_rdata;
  logic                      ram_ready;

  // Reference model state.
  logic [TAG_W-1:0] model_tag   [2][`ICACHE_SETS];
  logic             model_valid [2][`ICACHE_SETS];
  logic             model_lru   [`ICACHE_SETS];
  logic [TAG_W-1:0] evicted_tag [`ICACHE_SETS];
  logic             evicted_any [`ICACHE_SETS];

  // Address pool.
  logic [IDX_W-1:0] set_pool [NUM_SETS];
  logic [TAG_W-1:0] tag_pool [NUM_SETS][NUM_TAGS];

  int hit_count;
  int miss_count;
  int evict_count;
  int reaccess_count;

  icache_top u_dut (
    .clk         (clk),
    .resetn      (resetn),
    .cpu_addr_i  (cpu_addr),
    .cpu_valid_i (cpu_valid),
    .cpu_dout_o  (cpu_dout),
    .cpu_ready_o (cpu_ready),
    .ram_addr_o  (ram_addr),
    .ram_valid_o (ram_valid),
    .ram_rdata_i (ram_rdata),
    .ram_ready_i (ram_ready)
  );

  tb_icache_mem u_mem (
    .clk         (clk),
    .resetn      (resetn),
    .ram_addr_i  (ram_addr),
    .ram_valid_i (ram_valid),
    .ram_rdata_o (ram_rdata),
    .ram_ready_o (ram_ready)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------
  // Reporting
  // ------------------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error at %0d ns: %s is 0x%08h, expected 0x%08h", $time, name, actual, expected);
      abort_run("Response did not match the reference model");
    end
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------

  // Memory contents as the word address times a constant XOR a constant.
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [31:0] word_addr;
    word_addr = addr >> `ICACHE_OFFSET_W;
    return (word_addr * 32'h9E3779B1) ^ 32'h5A5A5A5A;
  endfunction

  task automatic clear_model();
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      model_valid[0][s] = 1'b0;
      model_valid[1][s] = 1'b0;
      model_tag[0][s]   = '0;
      model_tag[1][s]   = '0;
      model_lru[s]      = 1'b0;
      evicted_tag[s]    = '0;
      evicted_any[s]    = 1'b0;
    end
  endtask

  // Predicts hit or miss and updates tags, valids and LRU.
  function automatic logic model_access(input logic [31:0] addr);
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             victim;
    logic             hit;
    idx = addr[`ICACHE_OFFSET_W +: IDX_W];
    tag = addr[`ICACHE_OFFSET_W + IDX_W +: TAG_W];
    hit = 1'b0;
    if (evicted_any[idx] && (evicted_tag[idx] == tag)) begin
      reaccess_count++;
    end
    for (int w = 0; w < 2; w++) begin
      if (model_valid[w][idx] && (model_tag[w][idx] == tag)) begin
        hit            = 1'b1;
        model_lru[idx] = (w == 0);
      end
    end
    if (!hit) begin
      // LRU bit names the victim, then points at the other way.
      victim = model_lru[idx];
      if (model_valid[victim][idx]) begin
        evicted_tag[idx] = model_tag[victim][idx];
        evicted_any[idx] = 1'b1;
        evict_count++;
      end
      model_tag[victim][idx]   = tag;
      model_valid[victim][idx] = 1'b1;
      model_lru[idx]           = !victim;
    end
    return hit;
  endfunction

  // ------------------------------
  // Stimulus
  // ------------------------------

  // Twelve distinct sets with three distinct tags each.
  task automatic build_pool();
    int          base;
    logic [31:0] rnd;
    base = $urandom_range(`ICACHE_SETS - 1, 0);
    for (int s = 0; s < NUM_SETS; s++) begin
      set_pool[s] = IDX_W'((base + 5 * s) % `ICACHE_SETS);
      for (int t = 0; t < NUM_TAGS; t++) begin
        rnd            = $urandom();
        tag_pool[s][t] = {rnd[TAG_W-3:0], t[1:0]};
      end
    end
  endtask

  function automatic logic [31:0] random_addr();
    int s;
    int t;
    s = $urandom_range(NUM_SETS - 1, 0);
    t = $urandom_range(NUM_TAGS - 1, 0);
    return {tag_pool[s][t], set_pool[s], {`ICACHE_OFFSET_W{1'b0}}};
  endfunction

  // One cycle with no request. Nothing may answer.
  task automatic idle_cycle();
    cpu_valid = 1'b0;
    cpu_addr  = $urandom();
    @(posedge clk);
    check_value("cpu_ready_o", 32'(cpu_ready), 32'd0);
    check_value("ram_valid_o", 32'(ram_valid), 32'd0);
    @(negedge clk);
  endtask

  // Drives one fetch from a falling edge and checks every cycle until the response.
  task automatic run_fetch(input logic [31:0] addr);
    logic predicted_hit;
    logic expect_valid;
    logic expect_ready;
    logic done;
    int   cycle;
    predicted_hit = model_access(addr);
    if (predicted_hit) begin
      hit_count++;
    end else begin
      miss_count++;
    end
    cpu_addr  = addr;
    cpu_valid = 1'b1;
    cycle     = 0;
    done      = 1'b0;
    while (!done) begin
      @(posedge clk);
      // Cycle 0 is the acceptance cycle.
      expect_valid = !predicted_hit && (cycle >= 1);
      check_value("ram_valid_o", 32'(ram_valid), 32'(expect_valid));
      if (ram_valid) begin
        check_value("ram_addr_o", ram_addr, addr);
      end
      if (predicted_hit) begin
        expect_ready = (cycle == 1);
      end else begin
        expect_ready = (cycle >= 1) && ram_ready;
      end
      check_value("cpu_ready_o", 32'(cpu_ready), 32'(expect_ready));
      if (cpu_ready) begin
        check_value("cpu_dout_o", cpu_dout, expected_word(addr));
        done = 1'b1;
      end
      cycle++;
      @(negedge clk);
    end
  endtask

  // ------------------------------
  // Main sequence and watchdog
  // ------------------------------

  initial begin
    void'($urandom(24391));
    resetn         = 1'b0;
    cpu_valid      = 1'b0;
    cpu_addr       = '0;
    hit_count      = 0;
    miss_count     = 0;
    evict_count    = 0;
    reaccess_count = 0;
    clear_model();
    build_pool();
    repeat (2) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    for (int i = 0; i < NUM_REQ; i++) begin
      if ($urandom_range(3, 0) == 0) begin
        idle_cycle();
      end
      run_fetch(random_addr());
    end
    idle_cycle();
    $display("Fetches: %0d hits, %0d misses, %0d evictions, %0d evicted tags fetched again",
             hit_count, miss_count, evict_count, reaccess_count);
    if ((hit_count == 0) || (miss_count == 0) || (reaccess_count == 0)) begin
      abort_run("Request stream did not exercise hits, misses and LRU evictions");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

  // Twelve cycles per fetch covers the longest miss plus an idle gap.
  initial begin
    #(NUM_REQ * 12 * CLK_PERIOD);
    abort_run("Watchdog expired before all fetches completed");
  end

endmodule

`default_nettype wire

// File: verif/tb_icache_mem.sv
/* Backing memory for the cache testbench, answering each read after a random wait.
   Returned words follow a fixed rule of the word address, so the testbench can predict them. */
`timescale 1ns/100ps
`default_nettype none

`include "icache_consts.svh"

module tb_icache_mem (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic [`ICACHE_WORD_W-1:0] ram_addr_i,
  input  logic                      ram_valid_i,
  output logic [`ICACHE_WORD_W-1:0] ram_rdata_o,
  output logic                      ram_ready_o
);

  localparam int                      MAX_WAIT = 7;
  localparam logic [`ICACHE_WORD_W-1:0] HASH_MUL = 32'h9E3779B1;
  localparam logic [`ICACHE_WORD_W-1:0] HASH_XOR = 32'h5A5A5A5A;

  logic busy;
  int   wait_cnt;

  // Word stored at a byte address.
  function automatic logic [`ICACHE_WORD_W-1:0] word_for(input logic [`ICACHE_WORD_W-1:0] addr);
    logic [`ICACHE_WORD_W-1:0] word_addr;
    word_addr = addr >> `ICACHE_OFFSET_W;
    return (word_addr * HASH_MUL) ^ HASH_XOR;
  endfunction

  // Present the data for the held address.
  task automatic answer();
    ram_ready_o = 1'b1;
    ram_rdata_o = word_for(ram_addr_i);
  endtask

  // ------------------------------
  // Responder, driven on the falling edge
  // ------------------------------

  initial begin
    ram_ready_o = 1'b0;
    ram_rdata_o = '0;
    busy        = 1'b0;
    wait_cnt    = 0;
    forever begin
      @(negedge clk);
      if (!resetn) begin
        ram_ready_o = 1'b0;
        busy        = 1'b0;
        wait_cnt    = 0;
      end else if (ram_ready_o) begin
        // Single-cycle pulse, then junk on the data bus.
        ram_ready_o = 1'b0;
        ram_rdata_o = $urandom();
        busy        = 1'b0;
      end else if (ram_valid_i && !busy) begin
        wait_cnt = $urandom_range(MAX_WAIT, 0);
        if (wait_cnt == 0) begin
          answer();
        end else begin
          busy = 1'b1;
        end
      end else if (busy) begin
        wait_cnt--;
        if (wait_cnt == 0) begin
          answer();
        end
      end
    end
  end

endmodule

`default_nettype wire
